// File: filelist.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_core_top.sv
verification/core_assertions.sv
verification/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_tb -f filelist.f -o core_sim
./obj_dir/core_sim

// File: verification/core_tb.sv
module core_tb;

  logic        clock;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] fetch_pc;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_wdata;
  logic        redirect;

  logic [31:0] prog_mem [0:255];
  logic [31:0] prog_q [$];
  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_wdata [$];
  logic        exp_redirect [$];
  logic [31:0] halt_pc;
  logic [31:0] seed;
  logic        feed;
  logic        bubbles;
  logic        checking;
  logic        reset_q;
  logic        redirect_q;
  int          cycles;
  int          cycle_limit;

  rv_core_top i_rv_core_top (
    .clock        (clock),
    .reset        (reset),
    .fetch_pc     (fetch_pc),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata),
    .redirect     (redirect)
  );

  assign instr = prog_mem[fetch_pc[9:2]]; // Program memory answers the fetch PC.

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      stop_with("Mismatch against the ISA model.");
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Integer ops by funct3, as the ISA defines them.
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub_sra,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return sub_sra ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return sub_sra ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_run();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] res;
    logic [31:0] npc;
    logic [31:0] immi;
    logic [31:0] immb;
    logic        wr;
    logic        taken;
    int          steps;
    for (int r = 0; r < 32; r++) x[r] = 32'd0;
    pc = 32'd0;
    steps = 0;
    while (pc != halt_pc) begin
      w     = prog_mem[pc[9:2]];
      a     = x[w[19:15]];
      immi  = {{20{w[31]}}, w[31:20]};
      immb  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      npc   = pc + 32'd4;
      wr    = 1'b1;
      res   = 32'd0;
      taken = 1'b0;
      case (w[6:0])
        7'b0110111: res = {w[31:12], 12'd0};
        7'b0010111: res = pc + {w[31:12], 12'd0};
        7'b1101111: begin
          res = pc + 32'd4;
          npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        7'b1100111: begin
          res = pc + 32'd4;
          npc = (a + immi) & ~32'd1;
        end
        7'b1100011: begin
          wr = 1'b0;
          case (w[14:12])
            3'd0: taken = (a == x[w[24:20]]);
            3'd1: taken = (a != x[w[24:20]]);
            3'd4: taken = ($signed(a) < $signed(x[w[24:20]]));
            3'd5: taken = ($signed(a) >= $signed(x[w[24:20]]));
            3'd6: taken = (a < x[w[24:20]]);
            default: taken = (a >= x[w[24:20]]);
          endcase
          if (taken) npc = pc + immb;
        end
        7'b0010011: res = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, immi);
        default: res = alu_ref(w[14:12], w[30], a, x[w[24:20]]);
      endcase
      exp_pc.push_back(pc);
      exp_rd.push_back(wr ? w[11:7] : 5'd0);
      exp_wdata.push_back(res);
      exp_redirect.push_back(npc != pc + 32'd4);
      if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
      pc = npc;
      steps++;
      if (steps > 500) stop_with("The ISA model never reached the halt instruction.");
    end
  endtask

  // Each empty slot holds an ADDI to x0 carrying its own index.
  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      prog_mem[i] = {12'(i), 5'd0, 3'd0, 5'd0, 7'b0010011};
    end
    foreach (prog_q[i]) prog_mem[i] = prog_q[i];
    halt_pc = 32'(prog_q.size() * 4);
    prog_mem[prog_q.size()] = enc_j(21'd0, 5'd0); // Jump to itself.
    cycle_limit += (prog_q.size() + 1) * 4;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic run_program(input logic gaps);
    load_program();
    model_run();
    apply_reset();
    bubbles  <= gaps;
    checking <= 1'b1;
    feed     <= 1'b1;
    while (exp_pc.size() != 0) @(posedge clock);
    feed <= 1'b0;
    repeat (3) @(posedge clock);
    checking <= 1'b0;
    prog_q.delete();
  endtask

  always @(posedge clock) begin
    instr_valid <= feed && (!bubbles || ($random(seed) & 3) != 0);
    reset_q     <= reset;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) stop_with("Timeout, the retire list never drained.");
  end

  // Past the last expected retire only the halt jump may retire.
  always @(negedge clock) begin
    if (reset_q && retire_valid) stop_with("An instruction retired during reset.");
    if (checking && retire_valid) begin
      if (exp_pc.size() == 0) begin
        check("retire_pc", retire_pc, halt_pc);
        check("redirect", {31'd0, redirect_q}, 32'd1);
      end else begin
        check("retire_pc", retire_pc, exp_pc.pop_front());
        check("retire_rd", {27'd0, retire_rd}, {27'd0, exp_rd[0]});
        if (exp_rd[0] != 5'd0) check("retire_wdata", retire_wdata, exp_wdata[0]);
        check("redirect", {31'd0, redirect_q}, {31'd0, exp_redirect[0]});
        void'(exp_rd.pop_front());
        void'(exp_wdata.pop_front());
        void'(exp_redirect.pop_front());
      end
    end
    redirect_q = redirect; // Execute cycle of the next retire.
  end

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + {19'd0, value[11]};
    prog_q.push_back(enc_u(upper, rd, 7'b0110111));
    prog_q.push_back(enc_i(value[11:0], rd, 3'd0, rd, 7'b0010011));
  endtask

  task automatic alu_test();
    logic [11:0] imm;
    load_reg(5'd1, $random(seed));
    load_reg(5'd2, $random(seed));
    prog_q.push_back(enc_u(20'h80000, 5'd3, 7'b0110111));
    prog_q.push_back(enc_i(12'hfff, 5'd0, 3'd0, 5'd4, 7'b0010011));
    for (int f = 0; f < 8; f++) prog_q.push_back(enc_r(7'd0, 5'd2, 5'd1, 3'(f), 5'(10 + f)));
    prog_q.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd18));
    prog_q.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd19));
    prog_q.push_back(enc_r(7'h20, 5'd4, 5'd3, 3'd5, 5'd20)); // Arithmetic shift by 31.
    prog_q.push_back(enc_r(7'd0, 5'd1, 5'd4, 3'd3, 5'd21));
    prog_q.push_back(enc_r(7'd0, 5'd1, 5'd3, 3'd2, 5'd22));
    for (int f = 0; f < 8; f++) begin
      imm = 12'($random(seed));
      if (f == 1 || f == 5) imm = {7'd0, imm[4:0]};
      prog_q.push_back(enc_i(imm, 5'd1, 3'(f), 5'(23 + f), 7'b0010011));
    end
    prog_q.push_back(enc_i(12'h41f, 5'd3, 3'd5, 5'd31, 7'b0010011));
    run_program(1'b0);
  endtask

  task automatic forwarding_test();
    prog_q.push_back(enc_i(12'($random(seed)), 5'd0, 3'd0, 5'd1, 7'b0010011));
    prog_q.push_back(enc_r(7'd0, 5'd1, 5'd1, 3'd0, 5'd2));
    prog_q.push_back(enc_r(7'd0, 5'd1, 5'd2, 3'd4, 5'd3));
    prog_q.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
    prog_q.push_back(enc_i(12'd3, 5'd4, 3'd1, 5'd5, 7'b0010011));
    prog_q.push_back(enc_i(12'd5, 5'd5, 3'd0, 5'd0, 7'b0010011)); // Write to x0.
    prog_q.push_back(enc_r(7'd0, 5'd5, 5'd0, 3'd0, 5'd6));
    prog_q.push_back(enc_r(7'd0, 5'd0, 5'd6, 3'd6, 5'd7));
    prog_q.push_back(enc_r(7'd0, 5'd6, 5'd7, 3'd3, 5'd8));
  endtask

  task automatic branch_test();
    logic [2:0] f3s [6];
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    prog_q.push_back(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011));
    prog_q.push_back(enc_i(12'hffd, 5'd0, 3'd0, 5'd2, 7'b0010011));
    prog_q.push_back(enc_i(12'd5, 5'd0, 3'd0, 5'd3, 7'b0010011));
    prog_q.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd9, 7'b0010011));
    // Both operand orders give one taken and one fall-through per type.
    foreach (f3s[k]) begin
      prog_q.push_back(enc_b(13'd8, 5'd2, 5'd1, f3s[k]));
      prog_q.push_back(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'b0010011));
      prog_q.push_back(enc_b(13'd8, (k < 2) ? 5'd3 : 5'd1, (k < 2) ? 5'd1 : 5'd2, f3s[k]));
      prog_q.push_back(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'b0010011));
    end
    prog_q.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd11, 7'b0010011));
    prog_q.push_back(enc_i(12'hfff, 5'd11, 3'd0, 5'd11, 7'b0010011));
    prog_q.push_back(enc_b(13'h1ffc, 5'd0, 5'd11, 3'd1)); // Backward loop.
    run_program(1'b0);
  endtask

  task automatic jump_test();
    prog_q.push_back(enc_u(20'h12345, 5'd1, 7'b0010111));
    prog_q.push_back(enc_j(21'd8, 5'd2));
    prog_q.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd9, 7'b0010011));
    prog_q.push_back(enc_i(12'd25, 5'd0, 3'd0, 5'd4, 7'b0010011)); // Odd target.
    prog_q.push_back(enc_i(12'd0, 5'd4, 3'd0, 5'd5, 7'b1100111));
    prog_q.push_back(enc_i(12'd2, 5'd0, 3'd0, 5'd9, 7'b0010011));
    prog_q.push_back(enc_i(12'd33, 5'd0, 3'd0, 5'd7, 7'b0010011));
    prog_q.push_back(enc_i(12'd3, 5'd7, 3'd0, 5'd8, 7'b1100111));
    prog_q.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd9, 7'b0010011));
    prog_q.push_back(enc_j(21'd8, 5'd10));
    prog_q.push_back(enc_i(12'd4, 5'd0, 3'd0, 5'd9, 7'b0010011));
    run_program(1'b0);
  endtask

  task automatic bubble_reset_test();
    prog_q.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd12, 7'b0010011)); // Pass flag in x12.
    forwarding_test();
    prog_q.push_back(enc_b(13'd8, 5'd0, 5'd0, 3'd0));
    prog_q.push_back(enc_i(12'd7, 5'd0, 3'd0, 5'd9, 7'b0010011));
    prog_q.push_back(enc_b(13'd8, 5'd0, 5'd12, 3'd1)); // Leave after the second pass.
    prog_q.push_back(enc_j(21'h1fffd0, 5'd12)); // Back to the chain, second pass.
    load_program();
    model_run();
    apply_reset();
    bubbles  <= 1'b1;
    checking <= 1'b1;
    feed     <= 1'b1;
    while (exp_pc.size() > 10) @(posedge clock);
    checking <= 1'b0;
    feed     <= 1'b0;
    apply_reset();
    @(negedge clock);
    check("fetch_pc", fetch_pc, 32'h0000_0000);
    exp_pc.delete();
    exp_rd.delete();
    exp_wdata.delete();
    exp_redirect.delete();
    prog_q.delete();
    forwarding_test();
    run_program(1'b1);
  endtask

  initial begin
    seed        = 32'hbec8_ad61;
    reset       = 1'b1;
    instr_valid = 1'b0;
    feed        = 1'b0;
    bubbles     = 1'b0;
    checking    = 1'b0;
    reset_q     = 1'b0;
    redirect_q  = 1'b0;
    cycles      = 0;
    cycle_limit = 100;
    load_program();
    alu_test();
    forwarding_test();
    run_program(1'b0);
    branch_test();
    jump_test();
    bubble_reset_test();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verification/core_assertions.sv
module core_assertions (
  input logic        clock,
  input logic        reset,
  input logic        instr_valid,
  input logic        retire_valid,
  input logic        redirect,
  input logic [31:0] fetch_pc,
  input logic [31:0] redirect_pc
);

  retire_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(retire_valid))
    else $error("retire_valid is unknown");

  quiet_after_reset: assert property (@(posedge clock) $past(reset) |-> !retire_valid)
    else $error("retire_valid high in the cycle after reset");

  // Fetch follows the redirect target.
  redirect_taken: assert property (@(posedge clock) disable iff (reset)
    redirect |=> fetch_pc == $past(redirect_pc))
    else $error("fetch_pc did not load redirect_pc");

  squash_slot: assert property (@(posedge clock) disable iff (reset)
    (redirect && instr_valid) |-> ##2 !retire_valid)
    else $error("a squashed slot retired");

endmodule

bind rv_core_top core_assertions i_core_assertions (
  .clock        (clock),
  .reset        (reset),
  .instr_valid  (instr_valid),
  .retire_valid (retire_valid),
  .redirect     (redirect),
  .fetch_pc     (fetch_pc),
  .redirect_pc  (redirect_pc)
);

// File: logic/rv_core_top.sv
module rv_core_top (
  input  logic            clock,
  input  logic            reset,
  output logic [31:0]     fetch_pc,
  input  isa_pkg::instr_u instr,
  input  logic            instr_valid,
  output logic            retire_valid,
  output logic [31:0]     retire_pc,
  output logic [4:0]      retire_rd,
  output logic [31:0]     retire_wdata,
  output logic            redirect
);

  pipe_pkg::decoded_t     dec;
  pipe_pkg::exec_result_t exe;
  pipe_pkg::alu_op_e      alu_op;
  logic [31:0]            alu_a;
  logic [31:0]            alu_b;
  logic [31:0]            alu_result;
  logic [31:0]            redirect_pc;
  logic [4:0]             rs1_addr;
  logic [4:0]             rs2_addr;
  logic [31:0]            rs1_data;
  logic [31:0]            rs2_data;

  decode_stage i_decode_stage (
    .clock       (clock),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .exe         (exe),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .fetch_pc    (fetch_pc),
    .dec         (dec)
  );

  execute_stage i_execute_stage (
    .clock       (clock),
    .reset       (reset),
    .dec         (dec),
    .alu_op      (alu_op),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_result  (alu_result),
    .exe         (exe),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  alu i_alu (
    .alu_op (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  result_stage i_result_stage (
    .clock        (clock),
    .reset        (reset),
    .exe          (exe),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata)
  );

endmodule

// File: logic/result_stage.sv
module result_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  pipe_pkg::exec_result_t exe,
  input  logic [4:0]             rs1_addr,
  input  logic [4:0]             rs2_addr,
  output logic [31:0]            rs1_data,
  output logic [31:0]            rs2_data,
  output logic                   retire_valid,
  output logic [31:0]            retire_pc,
  output logic [4:0]             retire_rd,
  output logic [31:0]            retire_wdata
);

  logic [31:0] regs [1:31]; // x0 has no storage.
  logic        write_en;

  assign write_en = exe.valid && exe.reg_write && (exe.rd != 5'd0);

  always_ff @(posedge clock) begin
    if (write_en) begin
      regs[exe.rd] <= exe.wdata;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= exe.valid;
    end
  end

  // Retire payload.
  always_ff @(posedge clock) begin
    retire_pc    <= exe.pc;
    retire_rd    <= exe.reg_write ? exe.rd : 5'd0; // Zero when nothing is written.
    retire_wdata <= exe.wdata;
  end

endmodule

// File: logic/execute_stage.sv
module execute_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  pipe_pkg::decoded_t     dec,
  output pipe_pkg::alu_op_e      alu_op,
  output logic [31:0]            alu_a,
  output logic [31:0]            alu_b,
  input  logic [31:0]            alu_result,
  output pipe_pkg::exec_result_t exe,
  output logic                   redirect,
  output logic [31:0]            redirect_pc
);

  pipe_pkg::decoded_t d;
  logic [31:0]        link;
  logic [31:0]        target;
  logic [31:0]        next_pc;

  // The word fetched alongside a taken jump is dropped here.
  always_ff @(posedge clock) begin
    d <= dec;
    if (reset || redirect) begin
      d.valid <= 1'b0;
    end
  end

  assign alu_op = d.alu_op;
  assign alu_a  = d.a_val;
  assign alu_b  = d.b_val;

  assign link   = d.pc + 32'd4;
  assign target = d.pc + d.imm;

  always_comb begin
    case (d.npc_sel)
      pipe_pkg::NPC_JAL:    next_pc = target;
      pipe_pkg::NPC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      pipe_pkg::NPC_BRANCH: next_pc = alu_result[0] ? target : link;
      default:              next_pc = link;
    endcase
  end

  assign redirect    = d.valid && (next_pc != link);
  assign redirect_pc = next_pc;

  always_comb begin
    exe.valid     = d.valid;
    exe.pc        = d.pc;
    exe.rd        = d.rd;
    exe.reg_write = d.reg_write;
    exe.wdata     = (d.wdata_sel == pipe_pkg::WB_LINK) ? link : alu_result;
  end

endmodule

// File: logic/decode_stage.sv
module decode_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  isa_pkg::instr_u        instr,
  input  logic                   instr_valid,
  input  logic                   redirect,
  input  logic [31:0]            redirect_pc,
  input  pipe_pkg::exec_result_t exe,
  output logic [4:0]             rs1_addr,
  output logic [4:0]             rs2_addr,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  output logic [31:0]            fetch_pc,
  output pipe_pkg::decoded_t     dec
);

  logic [31:0]          imm;
  logic [31:0]          rs1_val;
  logic [31:0]          rs2_val;
  logic [31:0]          a_val;
  logic                 use_imm;
  logic                 alt;
  logic                 reg_write;
  pipe_pkg::op_sel_e    op_a;
  pipe_pkg::alu_op_e    alu_op;
  pipe_pkg::npc_sel_e   npc_sel;
  pipe_pkg::wdata_sel_e wdata_sel;

  function automatic pipe_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit,
                                                 input logic is_op);
    case (f3)
      isa_pkg::F3_ADD:  return (is_op && alt_bit) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  return pipe_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  return pipe_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: return pipe_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  return pipe_pkg::ALU_XOR;
      isa_pkg::F3_SR:   return alt_bit ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
      isa_pkg::F3_OR:   return pipe_pkg::ALU_OR;
      default:          return pipe_pkg::ALU_AND;
    endcase
  endfunction

  function automatic pipe_pkg::alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      isa_pkg::F3_BNE:  return pipe_pkg::ALU_NE;
      isa_pkg::F3_BLT:  return pipe_pkg::ALU_LT;
      isa_pkg::F3_BGE:  return pipe_pkg::ALU_GE;
      isa_pkg::F3_BLTU: return pipe_pkg::ALU_LTU;
      isa_pkg::F3_BGEU: return pipe_pkg::ALU_GEU;
      default:          return pipe_pkg::ALU_EQ; // BEQ and reserved codes.
    endcase
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= pipe_pkg::RESET_PC;
    end else if (redirect) begin
      fetch_pc <= redirect_pc;
    end else if (instr_valid) begin
      fetch_pc <= fetch_pc + 32'd4;
    end
  end

  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  // Result in execute is newer than the register file.
  assign rs1_val = (exe.valid && exe.reg_write && exe.rd != 5'd0 && exe.rd == rs1_addr) ?
                   exe.wdata : rs1_data;
  assign rs2_val = (exe.valid && exe.reg_write && exe.rd != 5'd0 && exe.rd == rs2_addr) ?
                   exe.wdata : rs2_data;

  assign alt = (instr.r.funct7 == isa_pkg::F7_ALT);

  always_comb begin
    imm       = '0;
    op_a      = pipe_pkg::OPA_ZERO;
    use_imm   = 1'b1;
    alu_op    = pipe_pkg::ALU_ADD;
    npc_sel   = pipe_pkg::NPC_SEQ;
    wdata_sel = pipe_pkg::WB_ALU;
    reg_write = 1'b0;
    case (instr.r.opcode)
      isa_pkg::OPC_LUI: begin
        imm       = {instr.u.imm_31_12, 12'b0};
        alu_op    = pipe_pkg::ALU_PASS_B;
        reg_write = 1'b1;
      end
      isa_pkg::OPC_AUIPC: begin
        imm       = {instr.u.imm_31_12, 12'b0};
        op_a      = pipe_pkg::OPA_PC;
        reg_write = 1'b1;
      end
      isa_pkg::OPC_JAL: begin
        imm       = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                     instr.j.imm_11, instr.j.imm_10_1, 1'b0};
        npc_sel   = pipe_pkg::NPC_JAL;
        wdata_sel = pipe_pkg::WB_LINK;
        reg_write = 1'b1;
      end
      isa_pkg::OPC_JALR: begin
        imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
        op_a      = pipe_pkg::OPA_RS1;
        npc_sel   = pipe_pkg::NPC_JALR;
        wdata_sel = pipe_pkg::WB_LINK;
        reg_write = 1'b1;
      end
      isa_pkg::OPC_BRANCH: begin
        imm     = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
        op_a    = pipe_pkg::OPA_RS1;
        use_imm = 1'b0;
        alu_op  = branch_op(instr.b.funct3);
        npc_sel = pipe_pkg::NPC_BRANCH;
      end
      isa_pkg::OPC_OP_IMM: begin
        imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
        op_a      = pipe_pkg::OPA_RS1;
        alu_op    = arith_op(instr.i.funct3, alt, 1'b0);
        reg_write = 1'b1;
      end
      isa_pkg::OPC_OP: begin
        op_a      = pipe_pkg::OPA_RS1;
        use_imm   = 1'b0;
        alu_op    = arith_op(instr.r.funct3, alt, 1'b1);
        reg_write = 1'b1;
      end
      default: ; // Unsupported opcodes retire as no-ops.
    endcase
  end

  always_comb begin
    case (op_a)
      pipe_pkg::OPA_RS1: a_val = rs1_val;
      pipe_pkg::OPA_PC:  a_val = fetch_pc;
      default:           a_val = '0;
    endcase
  end

  always_comb begin
    dec.valid     = instr_valid;
    dec.pc        = fetch_pc;
    dec.imm       = imm;
    dec.a_val     = a_val;
    dec.b_val     = use_imm ? imm : rs2_val;
    dec.alu_op    = alu_op;
    dec.npc_sel   = npc_sel;
    dec.wdata_sel = wdata_sel;
    dec.rd        = instr.r.rd;
    dec.reg_write = reg_write;
  end

endmodule

// File: logic/alu.sv
module alu (
  input  pipe_pkg::alu_op_e alu_op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result
);

  logic        eq;
  logic        lt_s;
  logic        lt_u;
  logic [4:0]  shamt;

  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);
  assign shamt = b[4:0];

  // Compares land in bit 0 for the branch decision.
  always_comb begin
    result = '0;
    case (alu_op)
      pipe_pkg::ALU_ADD:    result = a + b;
      pipe_pkg::ALU_SUB:    result = a - b;
      pipe_pkg::ALU_SLL:    result = a << shamt;
      pipe_pkg::ALU_SLT:    result = {31'b0, lt_s};
      pipe_pkg::ALU_SLTU:   result = {31'b0, lt_u};
      pipe_pkg::ALU_XOR:    result = a ^ b;
      pipe_pkg::ALU_SRL:    result = a >> shamt;
      pipe_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      pipe_pkg::ALU_OR:     result = a | b;
      pipe_pkg::ALU_AND:    result = a & b;
      pipe_pkg::ALU_PASS_B: result = b;
      pipe_pkg::ALU_EQ:     result = {31'b0, eq};
      pipe_pkg::ALU_NE:     result = {31'b0, !eq};
      pipe_pkg::ALU_LT:     result = {31'b0, lt_s};
      pipe_pkg::ALU_GE:     result = {31'b0, !lt_s};
      pipe_pkg::ALU_LTU:    result = {31'b0, lt_u};
      pipe_pkg::ALU_GEU:    result = {31'b0, !lt_u};
      default:              result = '0;
    endcase
  end

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    NPC_SEQ,
    NPC_JAL,
    NPC_JALR,
    NPC_BRANCH
  } npc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK
  } wdata_sel_e;

  typedef enum logic [1:0] {
    OPA_RS1,
    OPA_PC,
    OPA_ZERO
  } op_sel_e;

  // Decode to execute.
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] a_val;
    logic [31:0] b_val;
    alu_op_e     alu_op;
    npc_sel_e    npc_sel;
    wdata_sel_e  wdata_sel;
    logic [4:0]  rd;
    logic        reg_write;
  } decoded_t;

  // Execute to result.
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        reg_write;
    logic [31:0] wdata;
  } exec_result_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

  // Major opcodes of the supported RV32I subset.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  // One fetched word, viewed in each encoding.
  typedef union packed {
    r_type_t     r;
    i_type_t     i;
    s_type_t     s;
    b_type_t     b;
    u_type_t     u;
    j_type_t     j;
    logic [31:0] raw;
  } instr_u;

  // ALU selects for OP and OP-IMM.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch conditions.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA.

endpackage
